/* xlr8_pkg.sv */
`default_nettype none

package xlr8_pkg;

  //////////////////////////////
  // Widths and vector types
  //////////////////////////////
  localparam int IO_ADDR_W = 6;  // I/O register space
  localparam int DATA_W    = 8;  // Register and bus byte
  localparam int NUM_PINS  = 8;  // Port D pads

  typedef logic [IO_ADDR_W-1:0] io_addr_t;
  typedef logic [DATA_W-1:0]    io_data_t;
  typedef logic [NUM_PINS-1:0]  pin_vec_t;

  //////////////////////////////
  // I/O register map
  //////////////////////////////
  localparam io_addr_t GPIOR0_ADDR = 6'h1E;  // General purpose regs
  localparam io_addr_t GPIOR1_ADDR = 6'h2A;
  localparam io_addr_t GPIOR2_ADDR = 6'h2B;
  localparam io_addr_t PIND_ADDR   = 6'h09;  // Pad readback, read only
  localparam io_addr_t DDRD_ADDR   = 6'h0A;  // Direction, 1 is output
  localparam io_addr_t PORTD_ADDR  = 6'h0B;  // Output value
  localparam io_addr_t OSCCTL_ADDR = 6'h0C;  // Oscillator override control
  localparam io_addr_t SPCR1_ADDR  = 6'h20;  // First SPI master
  localparam io_addr_t SPSR1_ADDR  = 6'h21;
  localparam io_addr_t SPDR1_ADDR  = 6'h22;
  localparam io_addr_t SPCR2_ADDR  = 6'h23;  // Second SPI master
  localparam io_addr_t SPSR2_ADDR  = 6'h24;
  localparam io_addr_t SPDR2_ADDR  = 6'h25;

  // Bit positions
  localparam int SPE_BIT    = 6;  // SPCR enable
  localparam int MSTR_BIT   = 4;  // SPCR master select
  localparam int SPIF_BIT   = 7;  // SPSR transfer done
  localparam int OSC_EN_BIT = 0;  // OSCCTL override enable

  // Internal oscillator on a port D pin
  localparam int OSC_DIV = 1024;  // Output period in clocks
  localparam int OSC_PIN = 0;     // Pin taken over

  // sck period in clocks, indexed by SPR
  localparam int SPI_DIV_0 = 4;
  localparam int SPI_DIV_1 = 16;
  localparam int SPI_DIV_2 = 64;
  localparam int SPI_DIV_3 = 128;

endpackage

`default_nettype wire

/* io_bus_slave.sv */
`default_nettype none

module io_bus_slave (
  input  logic               Clock,
  input  logic               reset,
  // Host port, four-phase
  input  logic               req,
  input  logic               we,
  input  xlr8_pkg::io_addr_t addr,
  input  xlr8_pkg::io_data_t wdata,
  output logic               ack,
  output xlr8_pkg::io_data_t rdata,
  // Internal register bus
  output xlr8_pkg::io_addr_t adr,
  output xlr8_pkg::io_data_t dbus_in,
  output logic               iore,
  output logic               iowe,
  // Peripheral read returns
  input  xlr8_pkg::io_data_t spi1_rdata,
  input  logic               spi1_hit,
  input  xlr8_pkg::io_data_t spi2_rdata,
  input  logic               spi2_hit,
  input  xlr8_pkg::io_data_t gpio_rdata,
  input  logic               gpio_hit
);

  logic               busy;      // Strobe cycle in progress
  xlr8_pkg::io_data_t rd_merge;  // Winner of the read merge

  // Host keeps addr and wdata steady until ack, so pass them straight on
  assign adr     = addr;
  assign dbus_in = wdata;

  assign iowe = busy & we;   // One cycle per request
  assign iore = busy & ~we;

  // Fixed priority, unclaimed address reads 0
  assign rd_merge = spi1_hit ? spi1_rdata :
                    spi2_hit ? spi2_rdata :
                    gpio_hit ? gpio_rdata :
                               '0;

  //////////////////////////////
  // Handshake state
  //////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      busy  <= 1'b0;
      ack   <= 1'b0;
      rdata <= '0;
    end else begin
      if (busy) begin              // Strobe done, answer host
        busy <= 1'b0;
        ack  <= 1'b1;
      end else if (ack) begin
        ack <= req;                // Hold until host drops req
      end else if (req) begin
        busy <= 1'b1;              // New access accepted
      end
      if (iore) begin
        rdata <= rd_merge;         // Held while ack is high
      end
    end
  end

endmodule

`default_nettype wire

/* gpio_regs.sv */
`default_nettype none

module gpio_regs (
  input  logic               Clock,
  input  logic               reset,
  input  xlr8_pkg::io_addr_t adr,
  input  xlr8_pkg::io_data_t dbus_in,
  input  logic               iore,
  input  logic               iowe,
  input  xlr8_pkg::pin_vec_t pin_sync,  // Pads after synchronizer
  output xlr8_pkg::io_data_t dbus_out,
  output logic               out_en,
  output xlr8_pkg::pin_vec_t ddr,       // DDRD
  output xlr8_pkg::pin_vec_t port,      // PORTD
  output logic               osc_en
);

  xlr8_pkg::io_data_t gpior0;
  xlr8_pkg::io_data_t gpior1;
  xlr8_pkg::io_data_t gpior2;
  xlr8_pkg::io_data_t oscctl;
  xlr8_pkg::io_data_t rd_data;

  assign osc_en = oscctl[xlr8_pkg::OSC_EN_BIT];

  // Writes land on the strobe edge
  always_ff @(posedge Clock) begin
    if (reset) begin
      gpior0 <= '0;
      gpior1 <= '0;
      gpior2 <= '0;
      ddr    <= '0;
      port   <= '0;
      oscctl <= '0;
    end else if (iowe) begin
      case (adr)
        xlr8_pkg::GPIOR0_ADDR: gpior0 <= dbus_in;
        xlr8_pkg::GPIOR1_ADDR: gpior1 <= dbus_in;
        xlr8_pkg::GPIOR2_ADDR: gpior2 <= dbus_in;
        xlr8_pkg::DDRD_ADDR:   ddr    <= dbus_in;
        xlr8_pkg::PORTD_ADDR:  port   <= dbus_in;
        xlr8_pkg::OSCCTL_ADDR: oscctl <= dbus_in;
        default: ;                 // PIND and foreign addresses
      endcase
    end
  end

  // Address decode and readback
  always_comb begin
    rd_data = '0;
    out_en  = 1'b1;
    case (adr)
      xlr8_pkg::GPIOR0_ADDR: rd_data = gpior0;
      xlr8_pkg::GPIOR1_ADDR: rd_data = gpior1;
      xlr8_pkg::GPIOR2_ADDR: rd_data = gpior2;
      xlr8_pkg::DDRD_ADDR:   rd_data = ddr;
      xlr8_pkg::PORTD_ADDR:  rd_data = port;
      xlr8_pkg::OSCCTL_ADDR: rd_data = oscctl;
      xlr8_pkg::PIND_ADDR:   rd_data = pin_sync;  // Two clocks behind the pads
      default:               out_en  = 1'b0;
    endcase
  end

  assign dbus_out = iore ? rd_data : '0;  // Quiet outside read strobes

endmodule

`default_nettype wire

/* spi_master.sv */
`default_nettype none

module spi_master #(
  parameter xlr8_pkg::io_addr_t SPCR_ADDR = xlr8_pkg::SPCR1_ADDR,
  parameter xlr8_pkg::io_addr_t SPSR_ADDR = xlr8_pkg::SPSR1_ADDR,
  parameter xlr8_pkg::io_addr_t SPDR_ADDR = xlr8_pkg::SPDR1_ADDR
) (
  input  logic               Clock,
  input  logic               reset,
  input  xlr8_pkg::io_addr_t adr,
  input  xlr8_pkg::io_data_t dbus_in,
  input  logic               iore,
  input  logic               iowe,
  input  logic               miso,
  output xlr8_pkg::io_data_t dbus_out,
  output logic               out_en,
  output logic               sck,
  output logic               mosi
);

  localparam int CNT_W = $clog2(xlr8_pkg::SPI_DIV_3);  // Fits the slowest half period

  xlr8_pkg::io_data_t spcr;       // Control as written
  xlr8_pkg::io_data_t spsr;       // Status view
  xlr8_pkg::io_data_t spdr;       // Data and shift register
  xlr8_pkg::io_data_t rd_data;
  logic               spif;
  logic               busy;       // Transfer running
  logic               sck_q;
  logic               miso_q;     // Bit taken at sck rise
  logic [2:0]         bit_cnt;
  logic [CNT_W-1:0]   div_cnt;
  logic [CNT_W-1:0]   half_last;  // Last count of a half period
  logic               spe;
  logic               mstr;
  logic               half_done;

  assign spe       = spcr[xlr8_pkg::SPE_BIT];
  assign mstr      = spcr[xlr8_pkg::MSTR_BIT];
  assign half_done = (div_cnt == half_last);

  // SPR picks the sck rate
  always_comb begin
    case (spcr[1:0])
      2'd0:    half_last = CNT_W'(xlr8_pkg::SPI_DIV_0 / 2 - 1);
      2'd1:    half_last = CNT_W'(xlr8_pkg::SPI_DIV_1 / 2 - 1);
      2'd2:    half_last = CNT_W'(xlr8_pkg::SPI_DIV_2 / 2 - 1);
      default: half_last = CNT_W'(xlr8_pkg::SPI_DIV_3 / 2 - 1);
    endcase
  end

  //////////////////////////////
  // Registers and shifter
  //////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      spcr    <= '0;
      spif    <= 1'b0;
      spdr    <= '0;
      busy    <= 1'b0;
      sck_q   <= 1'b0;
      bit_cnt <= '0;
      div_cnt <= '0;
    end else begin
      if (!busy) begin
        if (iowe && adr == SPDR_ADDR) begin  // Load, maybe start
          spdr    <= dbus_in;
          spif    <= 1'b0;
          busy    <= spe & mstr;
          div_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (half_done) begin
        div_cnt <= '0;
        sck_q   <= ~sck_q;
        if (sck_q) begin                     // Falling edge, next bit out
          spdr    <= {spdr[6:0], miso_q};
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            busy <= 1'b0;
            spif <= 1'b1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (iowe && adr == SPCR_ADDR) begin
        spcr <= dbus_in;
        if (!dbus_in[xlr8_pkg::SPE_BIT]) begin  // Disable aborts a transfer
          busy  <= 1'b0;
          sck_q <= 1'b0;
        end
      end
    end
  end

  // Sample where sck rises
  always_ff @(posedge Clock) begin
    if (busy && half_done && !sck_q) begin
      miso_q <= miso;
    end
  end

  assign sck  = sck_q;            // Idles low, mode 0
  assign mosi = busy & spdr[7];   // MSB first

  // Readback
  always_comb begin
    spsr                     = '0;
    spsr[xlr8_pkg::SPIF_BIT] = spif;
    rd_data                  = '0;
    out_en                   = 1'b1;
    case (adr)
      SPCR_ADDR: rd_data = spcr;
      SPSR_ADDR: rd_data = spsr;
      SPDR_ADDR: rd_data = spdr;
      default:   out_en  = 1'b0;
    endcase
  end

  assign dbus_out = iore ? rd_data : '0;

endmodule

`default_nettype wire

/* port_driver.sv */
`default_nettype none

module port_driver (
  input  logic               Clock,
  input  logic               reset,
  input  xlr8_pkg::pin_vec_t ddr,
  input  xlr8_pkg::pin_vec_t port,
  input  logic               osc_en,
  input  xlr8_pkg::pin_vec_t pad_in,
  output xlr8_pkg::pin_vec_t pad_out,
  output xlr8_pkg::pin_vec_t pad_oe,
  output xlr8_pkg::pin_vec_t pin_sync
);

  localparam int DIV_W = $clog2(xlr8_pkg::OSC_DIV);

  logic [DIV_W-1:0]   osc_cnt;   // MSB is the divided clock
  xlr8_pkg::pin_vec_t pin_meta;  // First synchronizer stage

  //////////////////////////////
  // Oscillator divider
  //////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      osc_cnt <= '0;
    end else begin
      osc_cnt <= osc_cnt + 1'b1;  // Free running, MSB flips every OSC_DIV/2
    end
  end

  // Xcelerator override on one pin, rest straight from registers
  always_comb begin
    pad_oe  = ddr;
    pad_out = port;
    if (osc_en) begin
      pad_oe[xlr8_pkg::OSC_PIN]  = 1'b1;             // Forced output
      pad_out[xlr8_pkg::OSC_PIN] = osc_cnt[DIV_W-1];
    end
  end

  // Two flop input sync
  always_ff @(posedge Clock) begin
    if (reset) begin
      pin_meta <= '0;
      pin_sync <= '0;
    end else begin
      pin_meta <= pad_in;
      pin_sync <= pin_meta;
    end
  end

endmodule

`default_nettype wire

/* xlr8_io_top.sv */
`default_nettype none

module xlr8_io_top (
  input  logic               Clock,
  input  logic               reset,
  // Host port
  input  logic               req,
  input  logic               we,
  input  xlr8_pkg::io_addr_t addr,
  input  xlr8_pkg::io_data_t wdata,
  output logic               ack,
  output xlr8_pkg::io_data_t rdata,
  // Port D pads
  input  xlr8_pkg::pin_vec_t portd_in,
  output xlr8_pkg::pin_vec_t portd_out,
  output xlr8_pkg::pin_vec_t portd_oe,
  // SPI pads
  input  logic               spi1_miso,
  output logic               spi1_sck,
  output logic               spi1_mosi,
  input  logic               spi2_miso,
  output logic               spi2_sck,
  output logic               spi2_mosi
);

  xlr8_pkg::io_addr_t adr;          // Register bus
  xlr8_pkg::io_data_t dbus_in;
  logic               iore;
  logic               iowe;
  xlr8_pkg::io_data_t spi1_dbusout; // Read returns
  logic               spi1_out_en;
  xlr8_pkg::io_data_t spi2_dbusout;
  logic               spi2_out_en;
  xlr8_pkg::io_data_t gpio_dbusout;
  logic               gpio_out_en;
  xlr8_pkg::pin_vec_t ddr;          // Port D control
  xlr8_pkg::pin_vec_t port;
  logic               osc_en;
  xlr8_pkg::pin_vec_t pin_sync;

  //////////////////////////////
  // Host side
  //////////////////////////////
  io_bus_slave bus_slave_inst (
    .Clock      (Clock),
    .reset      (reset),
    .req        (req),
    .we         (we),
    .addr       (addr),
    .wdata      (wdata),
    .ack        (ack),
    .rdata      (rdata),
    .adr        (adr),
    .dbus_in    (dbus_in),
    .iore       (iore),
    .iowe       (iowe),
    .spi1_rdata (spi1_dbusout),
    .spi1_hit   (spi1_out_en),
    .spi2_rdata (spi2_dbusout),
    .spi2_hit   (spi2_out_en),
    .gpio_rdata (gpio_dbusout),
    .gpio_hit   (gpio_out_en)
  );

  //////////////////////////////
  // Peripherals
  //////////////////////////////
  gpio_regs gpio_inst (
    .Clock    (Clock),
    .reset    (reset),
    .adr      (adr),
    .dbus_in  (dbus_in),
    .iore     (iore),
    .iowe     (iowe),
    .pin_sync (pin_sync),
    .dbus_out (gpio_dbusout),
    .out_en   (gpio_out_en),
    .ddr      (ddr),
    .port     (port),
    .osc_en   (osc_en)
  );

  spi_master #(
    .SPCR_ADDR (xlr8_pkg::SPCR1_ADDR),
    .SPSR_ADDR (xlr8_pkg::SPSR1_ADDR),
    .SPDR_ADDR (xlr8_pkg::SPDR1_ADDR)
  ) spi_1 (
    .Clock    (Clock),
    .reset    (reset),
    .adr      (adr),
    .dbus_in  (dbus_in),
    .iore     (iore),
    .iowe     (iowe),
    .miso     (spi1_miso),
    .dbus_out (spi1_dbusout),
    .out_en   (spi1_out_en),
    .sck      (spi1_sck),
    .mosi     (spi1_mosi)
  );

  spi_master #(
    .SPCR_ADDR (xlr8_pkg::SPCR2_ADDR),
    .SPSR_ADDR (xlr8_pkg::SPSR2_ADDR),
    .SPDR_ADDR (xlr8_pkg::SPDR2_ADDR)
  ) spi_2 (
    .Clock    (Clock),
    .reset    (reset),
    .adr      (adr),
    .dbus_in  (dbus_in),
    .iore     (iore),
    .iowe     (iowe),
    .miso     (spi2_miso),
    .dbus_out (spi2_dbusout),
    .out_en   (spi2_out_en),
    .sck      (spi2_sck),
    .mosi     (spi2_mosi)
  );

  // Pads
  port_driver port_driver_inst (
    .Clock    (Clock),
    .reset    (reset),
    .ddr      (ddr),
    .port     (port),
    .osc_en   (osc_en),
    .pad_in   (portd_in),
    .pad_out  (portd_out),
    .pad_oe   (portd_oe),
    .pin_sync (pin_sync)
  );

endmodule

`default_nettype wire

/* tb_xlr8_io_assert.sv */
`default_nettype none

module tb_xlr8_io_assert (
  input logic               Clock,
  input logic               reset,
  input logic               req,
  input logic               ack,
  input logic               spi1_sck,
  input logic               spi2_sck,
  input logic               spi1_spe,  // SPCR enable bits from inside the DUT
  input logic               spi2_spe,
  input xlr8_pkg::pin_vec_t portd_oe
);

  int fail_cnt = 0;  // Read by the testbench top

  //////////////////////////////
  // Handshake rules
  //////////////////////////////
  ack_needs_req: assert property (@(posedge Clock) disable iff (reset)
    $rose(ack) |-> $past(req))
    else begin
      $error("ack rose without a pending req");
      fail_cnt++;
    end

  ack_holds: assert property (@(posedge Clock) disable iff (reset)
    ack && req |=> ack)
    else begin
      $error("ack fell while req was still high");
      fail_cnt++;
    end

  //////////////////////////////
  // Pad rules
  //////////////////////////////
  sck1_idle: assert property (@(posedge Clock) disable iff (reset)
    !spi1_spe |-> !spi1_sck)
    else begin
      $error("spi1 sck high with SPE clear");
      fail_cnt++;
    end

  sck2_idle: assert property (@(posedge Clock) disable iff (reset)
    !spi2_spe |-> !spi2_sck)
    else begin
      $error("spi2 sck high with SPE clear");
      fail_cnt++;
    end

  oe_in_reset: assert property (@(posedge Clock)
    reset && $past(reset) |-> portd_oe == '0)  // Registers cleared after first edge
    else begin
      $error("portd_oe driven during reset");
      fail_cnt++;
    end

endmodule

bind xlr8_io_top tb_xlr8_io_assert assert_inst (
  .Clock    (Clock),
  .reset    (reset),
  .req      (req),
  .ack      (ack),
  .spi1_sck (spi1_sck),
  .spi2_sck (spi2_sck),
  .spi1_spe (spi_1.spcr[xlr8_pkg::SPE_BIT]),
  .spi2_spe (spi_2.spcr[xlr8_pkg::SPE_BIT]),
  .portd_oe (portd_oe)
);

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

module tb_checker (
  input  logic               Clock,
  input  logic               reset,
  input  logic               ack,
  input  xlr8_pkg::io_addr_t addr,
  input  xlr8_pkg::io_data_t rdata,
  input  logic               exp_valid,  // Current access is a checked read
  input  xlr8_pkg::io_data_t exp_rdata,
  input  logic               pad_chk,    // Host idle, pads must match
  input  xlr8_pkg::pin_vec_t portd_oe,
  input  xlr8_pkg::pin_vec_t portd_out,
  input  xlr8_pkg::pin_vec_t exp_oe,
  input  xlr8_pkg::pin_vec_t exp_out,
  input  xlr8_pkg::pin_vec_t out_mask,   // Bits of portd_out compared
  input  logic               osc_chk,    // Measure the oscillator pin
  input  logic               sck_chk,
  input  logic               spi1_sck,
  input  logic               spi2_sck,
  input  logic               test_end,
  input  int                 test_id,
  input  int                 host_errs,  // Timeouts counted by the host
  output int                 err_cnt,
  output int                 chk_cnt
);

  localparam int OSC_HALF = xlr8_pkg::OSC_DIV / 2;  // Clocks between toggles

  logic ack_q    = 1'b0;
  logic osc_q    = 1'b0;
  logic osc_last = 1'b0;
  int   half_cnt = 0;
  int   toggles  = 0;
  int   test_base = 0;
  int   errs;

  initial begin
    err_cnt = 0;
    chk_cnt = 0;
  end

  always @(posedge Clock) begin
    if (!reset) begin
      if (ack && !ack_q && exp_valid) begin  // Read just answered
        chk_cnt++;
        if (rdata !== exp_rdata) begin
          err_cnt++;
          $display("mismatch rdata addr %h: got %h, expected %h", addr, rdata, exp_rdata);
        end
      end
      if (pad_chk) begin
        chk_cnt++;
        if (portd_oe !== exp_oe) begin
          err_cnt++;
          $display("mismatch portd_oe: got %h, expected %h", portd_oe, exp_oe);
        end
        if ((portd_out & out_mask) !== (exp_out & out_mask)) begin
          err_cnt++;
          $display("mismatch portd_out: got %h, expected %h", portd_out & out_mask,
                   exp_out & out_mask);
        end
        if (ack !== 1'b0) begin
          err_cnt++;
          $display("ack is high while the host is idle");
        end
      end
      if (sck_chk && (spi1_sck !== 1'b0 || spi2_sck !== 1'b0)) begin
        err_cnt++;
        $display("sck left its idle level while SPE was clear");
      end
      // Oscillator pin half period
      if (osc_chk) begin
        if (!osc_q) begin          // Window opens
          toggles  = 0;
          half_cnt = 0;
        end else if (portd_out[xlr8_pkg::OSC_PIN] !== osc_last) begin
          if (toggles > 0) begin
            chk_cnt++;
            if (half_cnt != OSC_HALF) begin
              err_cnt++;
              $display("mismatch osc half period: got %h, expected %h", half_cnt, OSC_HALF);
            end
          end
          toggles++;
          half_cnt = 1;
        end else begin
          half_cnt++;
        end
        osc_last = portd_out[xlr8_pkg::OSC_PIN];
      end else if (osc_q && toggles < 2) begin
        err_cnt++;
        $display("oscillator pin did not toggle twice inside the window");
      end
      osc_q = osc_chk;
      ack_q = ack;
      if (test_end) begin          // One line per finished test
        errs = err_cnt + host_errs - test_base;
        $display("test %0d: %0s, %0d errors", test_id, (errs == 0) ? "ok" : "failed", errs);
        test_base = err_cnt + host_errs;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_xlr8_io.sv */
`default_nettype none

module tb_xlr8_io;

  localparam int ACK_LIMIT  = 50;   // Clocks per handshake phase
  localparam int POLL_LIMIT = 600;  // SPSR reads per transfer
  localparam xlr8_pkg::pin_vec_t OSC_BIT = xlr8_pkg::pin_vec_t'(1) << xlr8_pkg::OSC_PIN;

  logic Clock;
  logic reset;
  logic req;
  logic we;
  logic ack;
  logic spi1_miso;
  logic spi1_sck;
  logic spi1_mosi;
  logic spi2_miso;
  logic spi2_sck;
  logic spi2_mosi;
  xlr8_pkg::io_addr_t addr;
  xlr8_pkg::io_data_t wdata;
  xlr8_pkg::io_data_t rdata;
  xlr8_pkg::pin_vec_t portd_in;
  xlr8_pkg::pin_vec_t portd_out;
  xlr8_pkg::pin_vec_t portd_oe;

  // Published to the checker
  logic               exp_valid;
  xlr8_pkg::io_data_t exp_rdata;
  logic               pad_chk;
  xlr8_pkg::pin_vec_t exp_oe;
  xlr8_pkg::pin_vec_t exp_out;
  xlr8_pkg::pin_vec_t out_mask;
  logic               osc_chk;
  logic               sck_chk;
  logic               test_end;
  int                 test_id;
  int                 host_errs;
  int                 err_cnt;
  int                 chk_cnt;
  int                 total;

  xlr8_pkg::io_data_t shadow [0:63];  // Last written value per address
  xlr8_pkg::pin_vec_t pin_shadow;     // Held on portd_in
  logic [1:0]         spif_shadow;    // SPIF of spi_1 and spi_2
  logic [31:0]        lfsr;
  xlr8_pkg::io_data_t b1;
  xlr8_pkg::io_data_t b2;
  xlr8_pkg::io_data_t ctrl;

  assign spi1_miso = spi1_mosi;   // Loopback
  assign spi2_miso = ~spi2_mosi;  // Inverted loopback

  xlr8_io_top xlr8_io_top_i (
    .Clock     (Clock),
    .reset     (reset),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .ack       (ack),
    .rdata     (rdata),
    .portd_in  (portd_in),
    .portd_out (portd_out),
    .portd_oe  (portd_oe),
    .spi1_miso (spi1_miso),
    .spi1_sck  (spi1_sck),
    .spi1_mosi (spi1_mosi),
    .spi2_miso (spi2_miso),
    .spi2_sck  (spi2_sck),
    .spi2_mosi (spi2_mosi)
  );

  tb_checker check_i (
    .Clock     (Clock),
    .reset     (reset),
    .ack       (ack),
    .addr      (addr),
    .rdata     (rdata),
    .exp_valid (exp_valid),
    .exp_rdata (exp_rdata),
    .pad_chk   (pad_chk),
    .portd_oe  (portd_oe),
    .portd_out (portd_out),
    .exp_oe    (exp_oe),
    .exp_out   (exp_out),
    .out_mask  (out_mask),
    .osc_chk   (osc_chk),
    .sck_chk   (sck_chk),
    .spi1_sck  (spi1_sck),
    .spi2_sck  (spi2_sck),
    .test_end  (test_end),
    .test_id   (test_id),
    .host_errs (host_errs),
    .err_cnt   (err_cnt),
    .chk_cnt   (chk_cnt)
  );

  initial begin
    Clock = 1'b0;
    forever #2 Clock = ~Clock;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic rand_byte(output xlr8_pkg::io_data_t b);
    int i;
    b = '0;
    for (i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};  // One step per bit
    end
  endtask

  // Expected read value from the register map rules
  function automatic xlr8_pkg::io_data_t ref_read(input xlr8_pkg::io_addr_t a);
    case (a)
      xlr8_pkg::PIND_ADDR:  return pin_shadow;
      xlr8_pkg::SPSR1_ADDR: return xlr8_pkg::io_data_t'(spif_shadow[0]) << xlr8_pkg::SPIF_BIT;
      xlr8_pkg::SPSR2_ADDR: return xlr8_pkg::io_data_t'(spif_shadow[1]) << xlr8_pkg::SPIF_BIT;
      xlr8_pkg::GPIOR0_ADDR, xlr8_pkg::GPIOR1_ADDR, xlr8_pkg::GPIOR2_ADDR,
      xlr8_pkg::DDRD_ADDR, xlr8_pkg::PORTD_ADDR, xlr8_pkg::OSCCTL_ADDR,
      xlr8_pkg::SPCR1_ADDR, xlr8_pkg::SPDR1_ADDR, xlr8_pkg::SPCR2_ADDR,
      xlr8_pkg::SPDR2_ADDR: return shadow[a];
      default:              return '0;  // Unclaimed
    endcase
  endfunction

  // Received byte: SPI1 loops back, SPI2 loops back inverted
  function automatic xlr8_pkg::io_data_t spi_rx(input int unit, input xlr8_pkg::io_data_t sent);
    return (unit == 1) ? sent : ~sent;
  endfunction

  task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    while (ack !== level && n < ACK_LIMIT) begin
      @(posedge Clock);
      #1;
      n++;
    end
    if (ack !== level) begin
      $display("timeout: ack did not go to %0d during %0s", level, what);
      host_errs++;
    end
  endtask

  // One four-phase access, entered and left 1 unit after an edge
  task automatic host_access(input logic wr, input xlr8_pkg::io_addr_t a,
                             input xlr8_pkg::io_data_t d, input logic chk,
                             output xlr8_pkg::io_data_t rd);
    addr      = a;
    we        = wr;
    wdata     = d;
    exp_rdata = ref_read(a);
    exp_valid = chk & ~wr;
    req       = 1'b1;
    wait_ack(1'b1, wr ? "write" : "read");
    rd  = rdata;
    req = 1'b0;
    wait_ack(1'b0, "release");
    exp_valid = 1'b0;
  endtask

  task automatic write_reg(input xlr8_pkg::io_addr_t a, input xlr8_pkg::io_data_t d);
    xlr8_pkg::io_data_t rd;
    host_access(1'b1, a, d, 1'b0, rd);
    case (a)
      xlr8_pkg::SPDR1_ADDR: begin
        shadow[a]      = d;
        spif_shadow[0] = 1'b0;
      end
      xlr8_pkg::SPDR2_ADDR: begin
        shadow[a]      = d;
        spif_shadow[1] = 1'b0;
      end
      xlr8_pkg::GPIOR0_ADDR, xlr8_pkg::GPIOR1_ADDR, xlr8_pkg::GPIOR2_ADDR,
      xlr8_pkg::DDRD_ADDR, xlr8_pkg::PORTD_ADDR, xlr8_pkg::OSCCTL_ADDR,
      xlr8_pkg::SPCR1_ADDR, xlr8_pkg::SPCR2_ADDR: shadow[a] = d;
      default: ;  // Read only or unmapped
    endcase
  endtask

  task automatic read_check(input xlr8_pkg::io_addr_t a);
    xlr8_pkg::io_data_t rd;
    host_access(1'b0, a, '0, 1'b1, rd);
  endtask

  task automatic read_raw(input xlr8_pkg::io_addr_t a, output xlr8_pkg::io_data_t rd);
    host_access(1'b0, a, '0, 1'b0, rd);
  endtask

  task automatic spi_poll(input int unit, input xlr8_pkg::io_addr_t spsr_addr);
    xlr8_pkg::io_data_t st;
    int                 n;
    st = '0;
    n  = 0;
    while (!st[xlr8_pkg::SPIF_BIT] && n < POLL_LIMIT) begin
      read_raw(spsr_addr, st);
      n++;
    end
    if (!st[xlr8_pkg::SPIF_BIT]) begin
      $display("timeout: SPIF never set on spi_%0d", unit);
      host_errs++;
    end else begin
      spif_shadow[unit-1] = 1'b1;
    end
  endtask

  task automatic pad_window(input xlr8_pkg::pin_vec_t oe, input xlr8_pkg::pin_vec_t out,
                            input xlr8_pkg::pin_vec_t mask, input int clocks);
    exp_oe   = oe;
    exp_out  = out;
    out_mask = mask;
    pad_chk  = 1'b1;
    repeat (clocks) @(posedge Clock);
    #1;
    pad_chk = 1'b0;
  endtask

  task automatic finish_test();
    test_end = 1'b1;
    @(posedge Clock);
    #1;
    test_end = 1'b0;
    test_id++;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    reset       = 1'b1;
    req         = 1'b0;
    we          = 1'b0;
    addr        = '0;
    wdata       = '0;
    portd_in    = '0;
    exp_valid   = 1'b0;
    exp_rdata   = '0;
    pad_chk     = 1'b0;
    osc_chk     = 1'b0;
    sck_chk     = 1'b0;
    exp_oe      = '0;
    exp_out     = '0;
    out_mask    = '0;
    test_end    = 1'b0;
    test_id     = 1;
    host_errs   = 0;
    lfsr        = 32'h2caf;
    pin_shadow  = '0;
    spif_shadow = '0;
    for (int i = 0; i < 64; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge Clock);
    #1;
    reset = 1'b0;

    // 1: reset values, whole address space
    pad_window('0, '0, '1, 4);
    for (int i = 0; i < 64; i++) begin
      read_check(xlr8_pkg::io_addr_t'(i));
    end
    finish_test();

    // 2: GPIOR read back
    repeat (4) begin
      rand_byte(b1);
      write_reg(xlr8_pkg::GPIOR0_ADDR, b1);
      rand_byte(b1);
      write_reg(xlr8_pkg::GPIOR1_ADDR, b1);
      rand_byte(b1);
      write_reg(xlr8_pkg::GPIOR2_ADDR, b1);
      read_check(xlr8_pkg::GPIOR0_ADDR);
      read_check(xlr8_pkg::GPIOR1_ADDR);
      read_check(xlr8_pkg::GPIOR2_ADDR);
    end
    finish_test();

    // 3: port D direction, output and pin read
    rand_byte(b1);
    write_reg(xlr8_pkg::DDRD_ADDR, b1);
    rand_byte(b1);
    write_reg(xlr8_pkg::PORTD_ADDR, b1);
    read_check(xlr8_pkg::DDRD_ADDR);
    read_check(xlr8_pkg::PORTD_ADDR);
    pad_window(shadow[xlr8_pkg::DDRD_ADDR], shadow[xlr8_pkg::PORTD_ADDR], '1, 8);
    rand_byte(b1);
    portd_in = b1;
    repeat (3) @(posedge Clock);  // Past the two-flop delay
    #1;
    pin_shadow = b1;
    read_check(xlr8_pkg::PIND_ADDR);
    finish_test();

    // 4: oscillator override on pin 0
    write_reg(xlr8_pkg::OSCCTL_ADDR, xlr8_pkg::io_data_t'(1) << xlr8_pkg::OSC_EN_BIT);
    osc_chk = 1'b1;
    pad_window(shadow[xlr8_pkg::DDRD_ADDR] | OSC_BIT, shadow[xlr8_pkg::PORTD_ADDR], ~OSC_BIT,
               1200);
    osc_chk = 1'b0;
    write_reg(xlr8_pkg::OSCCTL_ADDR, '0);
    read_check(xlr8_pkg::OSCCTL_ADDR);
    pad_window(shadow[xlr8_pkg::DDRD_ADDR], shadow[xlr8_pkg::PORTD_ADDR], '1, 8);
    finish_test();

    // 5: SPI transfers at every SPR, then one with SPE clear
    for (int spr = 0; spr < 4; spr++) begin
      ctrl = (xlr8_pkg::io_data_t'(1) << xlr8_pkg::SPE_BIT) |
             (xlr8_pkg::io_data_t'(1) << xlr8_pkg::MSTR_BIT) | xlr8_pkg::io_data_t'(spr);
      write_reg(xlr8_pkg::SPCR1_ADDR, ctrl);
      write_reg(xlr8_pkg::SPCR2_ADDR, ctrl);
      rand_byte(b1);
      rand_byte(b2);
      write_reg(xlr8_pkg::SPDR1_ADDR, b1);
      write_reg(xlr8_pkg::SPDR2_ADDR, b2);
      spi_poll(1, xlr8_pkg::SPSR1_ADDR);
      spi_poll(2, xlr8_pkg::SPSR2_ADDR);
      shadow[xlr8_pkg::SPDR1_ADDR] = spi_rx(1, b1);
      shadow[xlr8_pkg::SPDR2_ADDR] = spi_rx(2, b2);
      read_check(xlr8_pkg::SPCR1_ADDR);
      read_check(xlr8_pkg::SPSR1_ADDR);
      read_check(xlr8_pkg::SPDR1_ADDR);
      read_check(xlr8_pkg::SPSR2_ADDR);
      read_check(xlr8_pkg::SPDR2_ADDR);
    end
    write_reg(xlr8_pkg::SPCR1_ADDR, xlr8_pkg::io_data_t'(1) << xlr8_pkg::MSTR_BIT);
    sck_chk = 1'b1;
    rand_byte(b1);
    write_reg(xlr8_pkg::SPDR1_ADDR, b1);  // Load only
    repeat (40) @(posedge Clock);
    #1;
    sck_chk = 1'b0;
    read_check(xlr8_pkg::SPSR1_ADDR);
    read_check(xlr8_pkg::SPDR1_ADDR);
    finish_test();

    repeat (2) @(posedge Clock);
    total = err_cnt + host_errs + xlr8_io_top_i.assert_inst.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", test_id - 1, chk_cnt, total);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
xlr8_pkg.sv
io_bus_slave.sv
gpio_regs.sv
spi_master.sv
port_driver.sv
xlr8_io_top.sv
tb_xlr8_io_assert.sv
tb_checker.sv
tb_xlr8_io.sv

/* Bender.yml */
package:
  name: xlr8_io

sources:
  - xlr8_pkg.sv
  - io_bus_slave.sv
  - gpio_regs.sv
  - spi_master.sv
  - port_driver.sv
  - xlr8_io_top.sv
  - target: test
    files:
      - tb_xlr8_io_assert.sv
      - tb_checker.sv
      - tb_xlr8_io.sv
